// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f filelist.f --top-module tb_cache_system -o sim

run: compile
	./obj_dir/sim | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

// File: cache_system.sv
`timescale 1ns/1ps

module cache_system #(
  parameter int RAM_LATENCY = 2
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 halt,
  input  logic                 dmemREN,
  input  logic                 dmemWEN,
  input  cpu_types_pkg::word_t dmemaddr,
  input  cpu_types_pkg::word_t dmemstore,
  output logic                 dhit,
  output cpu_types_pkg::word_t dmemload,
  output logic                 flushed
);
  import cpu_types_pkg::*;

  // cache to controller
  logic  dREN;
  logic  dWEN;
  logic  dwait;
  word_t daddr;
  word_t dstore;
  word_t dload;

  // controller to ram
  logic  ramREN;
  logic  ramWEN;
  logic  ramready;
  word_t ramaddr;
  word_t ramstore;
  word_t ramload;

  dcache dcache_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .halt      (halt),
    .dmemREN   (dmemREN),
    .dmemWEN   (dmemWEN),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .dwait     (dwait),
    .dload     (dload),
    .dhit      (dhit),
    .dmemload  (dmemload),
    .flushed   (flushed),
    .dREN      (dREN),
    .dWEN      (dWEN),
    .daddr     (daddr),
    .dstore    (dstore)
  );

  memory_control #(
    .RAM_LATENCY (RAM_LATENCY)
  ) memory_control_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .dREN     (dREN),
    .dWEN     (dWEN),
    .daddr    (daddr),
    .dstore   (dstore),
    .ramload  (ramload),
    .ramready (ramready),
    .dwait    (dwait),
    .dload    (dload),
    .ramREN   (ramREN),
    .ramWEN   (ramWEN),
    .ramaddr  (ramaddr),
    .ramstore (ramstore)
  );

  ram #(
    .RAM_LATENCY (RAM_LATENCY)
  ) ram_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .ramREN   (ramREN),
    .ramWEN   (ramWEN),
    .ramaddr  (ramaddr),
    .ramstore (ramstore),
    .ramload  (ramload),
    .ramready (ramready)
  );

endmodule

// File: cpu_types_pkg.sv
package cpu_types_pkg;

  // basic data word
  typedef logic [31:0] word_t;

  // data cache address split: tag, set index, block offset, byte offset
  localparam int DTAG_W = 26;
  localparam int DIDX_W = 3;
  localparam int DBLK_W = 1;
  localparam int DBYT_W = 2;

  typedef struct packed {
    logic [DTAG_W-1:0] tag;
    logic [DIDX_W-1:0] idx;
    logic [DBLK_W-1:0] blkoff;
    logic [DBYT_W-1:0] bytoff;
  } dcachef_t;

  // word address bits decoded by the ram, 4 KB
  localparam int RAM_DEPTH_W = 10;

  // initial ram word is its word address xor this key
  localparam word_t RAM_INIT_KEY = 32'h5a5a0000;

endpackage

// File: dcache.sv
`timescale 1ns/1ps

module dcache (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 halt,
  input  logic                 dmemREN,
  input  logic                 dmemWEN,
  input  cpu_types_pkg::word_t dmemaddr,
  input  cpu_types_pkg::word_t dmemstore,
  input  logic                 dwait,
  input  cpu_types_pkg::word_t dload,
  output logic                 dhit,
  output cpu_types_pkg::word_t dmemload,
  output logic                 flushed,
  output logic                 dREN,
  output logic                 dWEN,
  output cpu_types_pkg::word_t daddr,
  output cpu_types_pkg::word_t dstore
);
  import cpu_types_pkg::*;

  localparam int SETS  = 2 ** DIDX_W;
  localparam int WORDS = 2 ** DBLK_W;

  typedef enum logic [3:0] {
    IDLE,
    WB0,
    WB1,
    FETCH0,
    FETCH1,
    FLUSH_CHK,
    FLUSH0,
    FLUSH1,
    FLUSHED
  } state_t;

  state_t state, next_state;

  // two ways per set
  logic [DTAG_W-1:0]    tags [2][SETS];
  word_t                data [2][SETS][WORDS];
  logic [1:0][SETS-1:0] valid_q;
  logic [1:0][SETS-1:0] dirty_q;
  // most recently used way of each set
  logic [SETS-1:0]      lru;

  // flush walk, top bit is the way
  logic [DIDX_W:0]      fcnt;
  logic                 fway;
  logic [DIDX_W-1:0]    fset;
  logic                 flush_dirty;

  dcachef_t             req;
  dcachef_t             mem_addr;
  logic                 req_valid;
  logic                 hit0;
  logic                 hit1;
  logic                 hit;
  logic                 hway;
  logic                 vway;
  logic                 victim_dirty;
  logic [DBLK_W-1:0]    word_sel;

  assign req       = dcachef_t'(dmemaddr);
  assign req_valid = dmemREN || dmemWEN;

  // tag compare on both ways
  assign hit0 = valid_q[0][req.idx] && (tags[0][req.idx] == req.tag);
  assign hit1 = valid_q[1][req.idx] && (tags[1][req.idx] == req.tag);
  assign hit  = hit0 || hit1;
  assign hway = hit1;

  // victim is the way not used last
  assign vway         = ~lru[req.idx];
  assign victim_dirty = valid_q[vway][req.idx] && dirty_q[vway][req.idx];

  assign fway        = fcnt[DIDX_W];
  assign fset        = fcnt[DIDX_W-1:0];
  assign flush_dirty = valid_q[fway][fset] && dirty_q[fway][fset];

  // requests are ignored once halt is seen
  assign dhit     = (state == IDLE) && !halt && req_valid && hit;
  assign dmemload = data[hway][req.idx][req.blkoff];
  assign flushed  = (state == FLUSHED);

  assign dREN = (state == FETCH0) || (state == FETCH1);
  assign dWEN = (state == WB0) || (state == WB1) ||
                (state == FLUSH0) || (state == FLUSH1);

  // second word of the block in the *1 states
  assign word_sel = DBLK_W'((state == WB1) || (state == FETCH1) || (state == FLUSH1));

  always_comb begin : mem_addr_mux
    mem_addr        = '0;
    mem_addr.blkoff = word_sel;
    case (state)
      WB0, WB1: begin
        mem_addr.tag = tags[vway][req.idx];
        mem_addr.idx = req.idx;
      end
      FLUSH0, FLUSH1: begin
        mem_addr.tag = tags[fway][fset];
        mem_addr.idx = fset;
      end
      default: begin
        mem_addr.tag = req.tag;
        mem_addr.idx = req.idx;
      end
    endcase
  end

  assign daddr = word_t'(mem_addr);

  always_comb begin : store_mux
    case (state)
      WB0, WB1:       dstore = data[vway][req.idx][word_sel];
      FLUSH0, FLUSH1: dstore = data[fway][fset][word_sel];
      default:        dstore = '0;
    endcase
  end

  always_comb begin : next_state_logic
    next_state = state;
    case (state)
      IDLE: begin
        if (halt) begin
          next_state = FLUSH_CHK;
        end else if (req_valid && !hit) begin
          next_state = victim_dirty ? WB0 : FETCH0;
        end
      end
      WB0: begin
        if (!dwait) begin
          next_state = WB1;
        end
      end
      WB1: begin
        if (!dwait) begin
          next_state = FETCH0;
        end
      end
      FETCH0: begin
        if (!dwait) begin
          next_state = FETCH1;
        end
      end
      FETCH1: begin
        // block is installed at this edge, hit follows in idle
        if (!dwait) begin
          next_state = IDLE;
        end
      end
      FLUSH_CHK: begin
        if (flush_dirty) begin
          next_state = FLUSH0;
        end else if (fcnt == '1) begin
          next_state = FLUSHED;
        end
      end
      FLUSH0: begin
        if (!dwait) begin
          next_state = FLUSH1;
        end
      end
      FLUSH1: begin
        if (!dwait) begin
          next_state = (fcnt == '1) ? FLUSHED : FLUSH_CHK;
        end
      end
      FLUSHED: next_state = FLUSHED;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state   <= IDLE;
      valid_q <= '0;
      dirty_q <= '0;
      lru     <= '0;
      fcnt    <= '0;
    end else begin
      state <= next_state;
      case (state)
        IDLE: begin
          if (dhit) begin
            lru[req.idx] <= hway;
            if (dmemWEN) begin
              dirty_q[hway][req.idx] <= 1'b1;
            end
          end
        end
        FETCH0: begin
          // old contents are gone once the first word lands
          if (!dwait) begin
            valid_q[vway][req.idx] <= 1'b0;
          end
        end
        FETCH1: begin
          if (!dwait) begin
            valid_q[vway][req.idx] <= 1'b1;
            dirty_q[vway][req.idx] <= 1'b0;
          end
        end
        FLUSH_CHK: begin
          if (!flush_dirty) begin
            fcnt <= fcnt + 1'b1;
          end
        end
        FLUSH1: begin
          if (!dwait) begin
            dirty_q[fway][fset] <= 1'b0;
            fcnt                <= fcnt + 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // tag and data arrays
  always_ff @(posedge CLK) begin
    if (dhit && dmemWEN) begin
      data[hway][req.idx][req.blkoff] <= dmemstore;
    end
    if ((state == FETCH0 || state == FETCH1) && !dwait) begin
      data[vway][req.idx][word_sel] <= dload;
    end
    if (state == FETCH1 && !dwait) begin
      tags[vway][req.idx] <= req.tag;
    end
  end

  // one memory direction at a time
  assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN));

  // address held while the controller is busy
  assert property (@(posedge CLK) disable iff (!nRST)
    (dREN || dWEN) && dwait |=> $stable(daddr));

endmodule

// File: filelist.f
cpu_types_pkg.sv
dcache.sv
memory_control.sv
ram.sv
cache_system.sv
tb_cache_system.sv

// File: memory_control.sv
`timescale 1ns/1ps

module memory_control #(
  parameter int RAM_LATENCY = 2
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 dREN,
  input  logic                 dWEN,
  input  cpu_types_pkg::word_t daddr,
  input  cpu_types_pkg::word_t dstore,
  input  cpu_types_pkg::word_t ramload,
  input  logic                 ramready,
  output logic                 dwait,
  output cpu_types_pkg::word_t dload,
  output logic                 ramREN,
  output logic                 ramWEN,
  output cpu_types_pkg::word_t ramaddr,
  output cpu_types_pkg::word_t ramstore
);
  import cpu_types_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    DONE
  } state_t;

  state_t state, next_state;

  // the request served last, so it is not started again
  logic  last_ren;
  logic  last_wen;
  word_t last_addr;
  word_t load_q;

  logic  req;
  logic  new_req;
  logic  start;

  assign req     = dREN || dWEN;
  assign new_req = req && !((dREN == last_ren) && (dWEN == last_wen) &&
                            (daddr == last_addr));
  assign start   = (state == IDLE) && new_req;

  // ram sees the request from its first cycle
  assign ramREN   = dREN && (start || state == ACCESS);
  assign ramWEN   = dWEN && (start || state == ACCESS);
  assign ramaddr  = daddr;
  assign ramstore = dstore;

  // wait released only in the done cycle
  assign dwait = req && (state != DONE);
  assign dload = load_q;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (start) begin
          next_state = ramready ? DONE : ACCESS;
        end
      end
      ACCESS: begin
        if (ramready) begin
          next_state = DONE;
        end
      end
      DONE:    next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= IDLE;
      last_ren <= 1'b0;
      last_wen <= 1'b0;
    end else begin
      state <= next_state;
      if (state == DONE) begin
        last_ren <= dREN;
        last_wen <= dWEN;
      end else if (state == IDLE && !req) begin
        last_ren <= 1'b0;
        last_wen <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (ramready) begin
      load_q <= ramload;
    end
    if (state == DONE) begin
      last_addr <= daddr;
    end
  end

  // an access in flight keeps its enables and address until ramready
  assert property (@(posedge CLK) disable iff (!nRST)
    (ramREN || ramWEN) && !ramready |=>
      (ramREN || ramWEN) && $stable(ramWEN) && $stable(ramaddr));

  // ram answers within its latency
  assert property (@(posedge CLK) disable iff (!nRST)
    start |-> ##[0:RAM_LATENCY-1] ramready);

endmodule

// File: ram.sv
`timescale 1ns/1ps

module ram #(
  parameter int RAM_LATENCY = 2
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 ramREN,
  input  logic                 ramWEN,
  input  cpu_types_pkg::word_t ramaddr,
  input  cpu_types_pkg::word_t ramstore,
  output cpu_types_pkg::word_t ramload,
  output logic                 ramready
);
  import cpu_types_pkg::*;

  localparam int DEPTH = 2 ** RAM_DEPTH_W;
  localparam int CNT_W = $clog2(RAM_LATENCY + 1);

  word_t                  mem [DEPTH];
  logic [CNT_W-1:0]       cnt;
  logic                   req;
  logic [RAM_DEPTH_W-1:0] waddr;
  // set by the first reset, later resets leave the contents alone
  logic                   init_done = 1'b0;

  assign req   = ramREN || ramWEN;
  assign waddr = ramaddr[RAM_DEPTH_W+DBYT_W-1:DBYT_W];

  // ready in the last wait cycle of the access
  assign ramready = req && (cnt == CNT_W'(RAM_LATENCY - 1));
  assign ramload  = mem[waddr];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt <= '0;
      if (!init_done) begin
        // word address xor key
        for (int i = 0; i < DEPTH; i++) begin
          mem[i] <= word_t'(i) ^ RAM_INIT_KEY;
        end
        init_done <= 1'b1;
      end
    end else begin
      if (ramready || !req) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
      if (ramready && ramWEN) begin
        mem[waddr] <= ramstore;
      end
    end
  end

endmodule

// File: tb_cache_system.sv
`timescale 1ns/1ps

module tb_cache_system;
  import cpu_types_pkg::*;

  localparam int DEPTH   = 2 ** RAM_DEPTH_W;
  localparam int TIMEOUT = 200;

  // one stimulus row: operation, address, random data flag, fixed data
  typedef struct packed {
    logic  wr;
    word_t addr;
    logic  rnd;
    word_t data;
  } stim_t;

  logic  CLK;
  logic  nRST;
  logic  halt;
  logic  dmemREN;
  logic  dmemWEN;
  word_t dmemaddr;
  word_t dmemstore;
  logic  dhit;
  word_t dmemload;
  logic  flushed;

  stim_t       stim_q[$];
  word_t       ref_mem [DEPTH];
  logic        written [DEPTH];
  int          checks;
  int          errors;
  int          timeouts;
  int unsigned seed;

  cache_system #(
    .RAM_LATENCY (2)
  ) cache_system_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .halt      (halt),
    .dmemREN   (dmemREN),
    .dmemWEN   (dmemWEN),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .dhit      (dhit),
    .dmemload  (dmemload),
    .flushed   (flushed)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  task automatic check_value(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic int word_index(input word_t addr);
    return int'(addr[RAM_DEPTH_W+DBYT_W-1:DBYT_W]);
  endfunction

  function automatic word_t make_addr(input int tag, input int idx, input int blk);
    dcachef_t f;
    f        = '0;
    f.tag    = DTAG_W'(tag);
    f.idx    = DIDX_W'(idx);
    f.blkoff = DBLK_W'(blk);
    return word_t'(f);
  endfunction

  task automatic add_entry(input logic wr, input word_t addr, input logic rnd,
                           input word_t data);
    stim_t e;
    e.wr   = wr;
    e.addr = addr;
    e.rnd  = rnd;
    e.data = data;
    stim_q.push_back(e);
  endtask

  task automatic build_table();
    logic wr;
    int   tag;
    int   blk;
    // untouched word, clean miss
    add_entry(1'b0, make_addr(4, 0, 0), 1'b0, '0);
    // write miss, then both words of the block
    add_entry(1'b1, make_addr(2, 4, 1), 1'b0, 32'hcafe_0001);
    add_entry(1'b0, make_addr(2, 4, 1), 1'b0, '0);
    add_entry(1'b0, make_addr(2, 4, 0), 1'b0, '0);
    // three tags in set 5 force a dirty eviction
    for (int t = 1; t <= 3; t++) begin
      add_entry(1'b1, make_addr(t, 5, 0), 1'b1, '0);
    end
    for (int t = 1; t <= 3; t++) begin
      add_entry(1'b0, make_addr(t, 5, 0), 1'b0, '0);
    end
    // mixed traffic over all sets
    for (int k = 0; k < 48; k++) begin
      wr  = 1'($urandom % 2);
      tag = 1 + int'($urandom % 6);
      blk = int'($urandom % 2);
      add_entry(wr, make_addr(tag, k % 8, blk), 1'b1, '0);
    end
  endtask

  task automatic apply_reset();
    nRST      = 1'b0;
    halt      = 1'b0;
    dmemREN   = 1'b0;
    dmemWEN   = 1'b0;
    dmemaddr  = '0;
    dmemstore = '0;
    repeat (10) @(posedge CLK);
    #2;
    nRST = 1'b1;
    // nothing asked yet, so both stay low
    repeat (3) begin
      @(negedge CLK);
      check_value("dhit after reset", word_t'(dhit), '0);
      check_value("flushed after reset", word_t'(flushed), '0);
    end
    @(posedge CLK);
    #2;
  endtask

  task automatic access(input logic wr, input word_t addr, input word_t wdata);
    logic  got;
    int    cycles;
    word_t rdata;
    if (timeouts != 0) begin
      return;
    end
    got       = 1'b0;
    cycles    = 0;
    dmemREN   = !wr;
    dmemWEN   = wr;
    dmemaddr  = addr;
    dmemstore = wdata;
    while (!got && cycles < TIMEOUT) begin
      @(negedge CLK);
      got = (dhit === 1'b1);
      cycles++;
    end
    rdata = dmemload;
    @(posedge CLK);
    #2;
    dmemREN = 1'b0;
    dmemWEN = 1'b0;
    if (!got) begin
      timeouts++;
      $display("timeout: no dhit for address %h within %0d cycles", addr, TIMEOUT);
    end else if (wr) begin
      ref_mem[word_index(addr)] = wdata;
      written[word_index(addr)] = 1'b1;
    end else begin
      check_value($sformatf("read of %h", addr), rdata, ref_mem[word_index(addr)]);
    end
  endtask

  task automatic run_table();
    word_t wdata;
    foreach (stim_q[i]) begin
      wdata = stim_q[i].rnd ? $urandom : stim_q[i].data;
      access(stim_q[i].wr, stim_q[i].addr, wdata);
    end
  endtask

  task automatic wait_flushed();
    logic done;
    int   cycles;
    done   = 1'b0;
    cycles = 0;
    halt   = 1'b1;
    while (!done && cycles < TIMEOUT) begin
      @(negedge CLK);
      done = (flushed === 1'b1);
      cycles++;
    end
    if (!done) begin
      timeouts++;
      $display("timeout: flushed did not rise within %0d cycles of halt", TIMEOUT);
    end
    @(posedge CLK);
    #2;
  endtask

  initial begin
    nRST      = 1'b0;
    halt      = 1'b0;
    dmemREN   = 1'b0;
    dmemWEN   = 1'b0;
    dmemaddr  = '0;
    dmemstore = '0;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    seed      = $urandom(32'h76d8);
    // same fill rule as the ram
    for (int i = 0; i < DEPTH; i++) begin
      ref_mem[i] = word_t'(i) ^ RAM_INIT_KEY;
      written[i] = 1'b0;
    end
    build_table();
    apply_reset();
    run_table();
    wait_flushed();
    // cache comes back empty, ram keeps what the flush wrote
    apply_reset();
    for (int i = 0; i < DEPTH; i++) begin
      if (written[i]) begin
        access(1'b0, word_t'(i << DBYT_W), '0);
      end
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
